/* list.f */
+incdir+verilog
verilog/spi_pkg.sv
verilog/tdc_pkg.sv
verilog/tdc_spi_master.sv
verilog/tdc_reg_sequencer.sv
verilog/tdc_spi_top.sv
verification/tb_clock_gen.sv
verification/tdc_slave_model.sv
verification/tdc_spi_checker.sv
verification/tb_tdc_spi.sv

/* Makefile */
TOP := tb_tdc_spi

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module tdc_spi_top
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* verification/tb_tdc_spi.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tdc_params.svh"

module tb_tdc_spi;

  localparam int LIMIT = 2000; // cycles allowed per wait

  logic                   clk;
  logic                   rst;
  logic                   cmd_valid;
  logic                   cmd_write;
  logic [`TDC_ADDR_W-1:0] cmd_addr;
  logic [`TDC_DATA_W-1:0] cmd_wdata;
  logic                   cmd_ready;
  logic                   rsp_valid;
  logic [`TDC_DATA_W-1:0] rsp_data;
  logic                   rsp_ready;
  logic                   sck;
  logic                   mosi;
  logic                   cs_n;
  logic                   miso;
  int                     tests;
  int                     errors;
  int                     issued;
  int                     k;
  logic                   hung;
  integer                 seed;
  logic [31:0]            rnd;
  logic [31:0]            wrnd;

  tb_clock_gen #(.PERIOD(100)) u_clk (.*);

  tdc_spi_top UUT (.*);

  tdc_slave_model u_slave (.*);

  tdc_spi_checker u_chk (.*);

  // one command in, one response out, response held for hold cycles
  task automatic run_cmd(input logic wr, input logic [`TDC_ADDR_W-1:0] addr,
                         input logic [`TDC_DATA_W-1:0] wdata, input int hold);
    int n;
    if (hung) return;
    n = 0;
    while (!cmd_ready && n < LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!cmd_ready) begin
      $display("Timeout: cmd_ready never came back high");
      hung = 1'b1;
      return;
    end
    cmd_valid = 1'b1;
    cmd_write = wr;
    cmd_addr  = addr;
    cmd_wdata = wdata;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    issued++;
    n = 0;
    while (!rsp_valid && n < LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!rsp_valid) begin
      $display("Timeout: no response for the command to address %h", addr);
      hung = 1'b1;
      return;
    end
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    rsp_ready = 1'b1;
    @(posedge clk);
    #1;
    rsp_ready = 1'b0;
  endtask

  initial begin
    seed      = 32'h560d1e64;
    hung      = 1'b0;
    issued    = 0;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    rsp_ready = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // narrow write, then read it back
    rnd = $random(seed);
    run_cmd(1'b1, 6'd5, {rnd[23:8], 8'ha7}, 0);
    run_cmd(1'b0, 6'd5, '0, 0);
    // result registers at both ends of the wide range
    run_cmd(1'b0, 6'd16, '0, 0);
    run_cmd(1'b0, 6'd63, '0, 0);
    // response held back for a while
    rnd = $random(seed);
    run_cmd(1'b0, 6'd20, '0, 4 + int'(rnd[3:0]));
    run_cmd(1'b1, 6'd9, rnd[31:8], 4 + int'(rnd[7:4]));

    for (k = 0; k < 40; k++) begin
      rnd  = $random(seed);
      wrnd = $random(seed);
      run_cmd(rnd[31], rnd[5:0], wrnd[23:0], int'(rnd[9:8]));
    end

    repeat (4) @(posedge clk);
    $display("tests %0d of %0d, errors %0d", tests, issued, errors);
    if (errors == 0 && !hung && tests == issued) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tdc_spi_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tdc_params.svh"

// watches the command, response and spi sides of the DUT
module tdc_spi_checker import tdc_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   cmd_valid,
  input  wire logic                   cmd_ready,
  input  wire logic                   cmd_write,
  input  wire logic [`TDC_ADDR_W-1:0] cmd_addr,
  input  wire logic [`TDC_DATA_W-1:0] cmd_wdata,
  input  wire logic                   rsp_valid,
  input  wire logic                   rsp_ready,
  input  wire logic [`TDC_DATA_W-1:0] rsp_data,
  input  wire logic                   sck,
  input  wire logic                   mosi,
  input  wire logic                   cs_n,
  output int                          tests,
  output int                          errors
);

  logic [7:0]             shadow [0:`TDC_WIDE_BASE-1]; // past narrow writes
  tdc_cmd_u               exp_cmd;
  logic [`TDC_DATA_W-1:0] exp_rsp;
  logic [`TDC_DATA_W-1:0] last_data;
  logic [7:0]             mosi_sh;
  logic                   was_held;
  logic                   sck_d;
  logic                   cs_d;
  int                     edges;
  int                     exp_edges;
  int                     frames;    // cs_n frames since the command was taken
  string                  verdict;

  // converter command byte holds auto_inc, rw and addr from the msb down
  function automatic tdc_cmd_u ref_cmd(input logic wr, input logic [`TDC_ADDR_W-1:0] addr);
    tdc_cmd_u c;
    c.raw = {1'b0, wr, addr}; // burst bit always clear
    return c;
  endfunction

  function automatic logic [`TDC_DATA_W-1:0] ref_rsp(input logic wr,
                                                      input logic [`TDC_ADDR_W-1:0] addr);
    logic [7:0] a;
    a = {2'b00, addr};
    if (wr) begin
      return '0;
    end else if (addr < `TDC_WIDE_BASE) begin
      return {16'h0000, shadow[addr[3:0]]};
    end
    return {a + 8'd2, a + 8'd1, a}; // result registers hold addr + i in byte i
  endfunction

  task automatic report(input string msg);
    errors++;
    $display("Error at time %0t: %s", $time, msg);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      tests     = 0;
      errors    = 0;
      edges     = 0;
      exp_edges = 0;
      frames    = 0;
      was_held  = 1'b0;
      sck_d     = 1'b0;
      cs_d      = 1'b1;
      exp_cmd   = '0;
      shadow    = '{default: 8'h00};
    end else begin
      if (cmd_valid && cmd_ready) begin
        exp_cmd   = ref_cmd(cmd_write, cmd_addr);
        exp_rsp   = ref_rsp(cmd_write, cmd_addr);
        exp_edges = (cmd_addr < `TDC_WIDE_BASE) ? 16 : 32; // 2 or 4 bytes
        frames    = 0;
        if (cmd_write && cmd_addr < `TDC_WIDE_BASE) begin
          shadow[cmd_addr[3:0]] = cmd_wdata[7:0];
        end
      end
      if (sck && !sck_d) begin
        mosi_sh = {mosi_sh[6:0], mosi};
        edges++;
        if (cs_n) report("sck rising edge while cs_n is high");
        if (edges == 8 && mosi_sh != exp_cmd.raw) begin
          report($sformatf("command byte %h, expected %h", mosi_sh, exp_cmd.raw));
        end
      end
      if (cs_n && !cs_d) begin
        if (edges != exp_edges) begin
          report($sformatf("%0d sck edges under cs_n, expected %0d", edges, exp_edges));
        end
        edges = 0;
        frames++;
      end
      if (rsp_valid) begin
        if (cmd_ready || sck || !cs_n) report("bus active while a response is pending");
        if (was_held && rsp_data != last_data) report("rsp_data changed under back-pressure");
        if (rsp_ready) begin
          tests++;
          verdict = "ok";
          if (frames != 1) begin
            report($sformatf("%0d chip select frames for one command", frames));
            verdict = "mismatch";
          end
          if (rsp_data != exp_rsp) begin
            report($sformatf("rsp_data %h, expected %h", rsp_data, exp_rsp));
            verdict = "mismatch";
          end
          $display("test %0d: %s addr %h data %h %s", tests,
                   exp_cmd.fields.rw ? "write" : "read ", exp_cmd.fields.addr, rsp_data, verdict);
        end
      end
      was_held  = rsp_valid && !rsp_ready;
      last_data = rsp_data;
      sck_d     = sck;
      cs_d      = cs_n;
    end
  end

endmodule

`default_nettype wire

/* verification/tdc_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tdc_params.svh"

// converter register file as seen on its spi pins, mode 0
module tdc_slave_model (
  input  wire logic sck,
  input  wire logic mosi,
  input  wire logic cs_n,
  output logic      miso
);

  bit   [7:0]  regs [0:`TDC_WIDE_BASE-1]; // config registers, power up at zero
  logic [31:0] seen;                      // mosi bits of the current frame
  logic [23:0] out;                       // read data, msb on miso
  int          n;                         // rising sck edges since cs_n fell
  logic [7:0]  a;

  // command byte answers with zeros
  assign miso = (n >= 8) ? out[23] : 1'b0;

  always @(posedge sck or posedge cs_n) begin
    if (cs_n) begin
      // end of frame, a narrow write lands now
      if (n == 16 && seen[14] && seen[13:8] < `TDC_WIDE_BASE) begin
        regs[seen[11:8]] <= seen[7:0];
      end
      n <= 0;
    end else begin
      seen <= {seen[30:0], mosi};
      n    <= n + 1;
    end
  end

  // next bit goes out while sck is low
  always @(negedge sck) begin
    a = {2'b00, seen[5:0]};
    if (n == 8) begin
      if (seen[5:0] < `TDC_WIDE_BASE) begin
        out <= {regs[seen[3:0]], 16'h0000};
      end else begin
        out <= {a + 8'd2, a + 8'd1, a}; // byte i holds addr + i
      end
    end else begin
      out <= out << 1;
    end
  end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock, starts low
module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* verilog/tdc_spi_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tdc_params.svh"

module tdc_spi_top import tdc_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   cmd_valid,
  input  wire logic                   cmd_write,
  input  wire logic [`TDC_ADDR_W-1:0] cmd_addr,
  input  wire logic [`TDC_DATA_W-1:0] cmd_wdata,
  output logic                        cmd_ready,
  output logic                        rsp_valid,
  output logic [`TDC_DATA_W-1:0]      rsp_data,
  input  wire logic                   rsp_ready,
  output logic                        sck,
  output logic                        mosi,
  output logic                        cs_n,
  input  wire logic                   miso
);

  logic       start;
  logic       busy;
  logic       done;
  logic       cs_end;
  logic [7:0] rx_byte;
  tdc_cmd_u   tx_byte; // command byte or data byte, shifter sees it raw

  tdc_reg_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_write (cmd_write),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .rsp_ready (rsp_ready),
    .busy      (busy),
    .done      (done),
    .rx_byte   (rx_byte),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .start     (start),
    .tx_byte   (tx_byte),
    .cs_end    (cs_end)
  );

  tdc_spi_master #(
    .SCK_HALF (`TDC_SCK_HALF)
  ) u_spi (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .tx_byte (tx_byte.raw),
    .cs_end  (cs_end),
    .miso    (miso),
    .busy    (busy),
    .done    (done),
    .rx_byte (rx_byte),
    .sck     (sck),
    .mosi    (mosi),
    .cs_n    (cs_n)
  );

endmodule

`default_nettype wire

/* verilog/tdc_reg_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tdc_params.svh"

// one register access = command byte + 1 or 3 data bytes under one cs
module tdc_reg_sequencer import tdc_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   cmd_valid,
  input  wire logic                   cmd_write,
  input  wire logic [`TDC_ADDR_W-1:0] cmd_addr,
  input  wire logic [`TDC_DATA_W-1:0] cmd_wdata,
  input  wire logic                   rsp_ready,
  input  wire logic                   busy,
  input  wire logic                   done,
  input  wire logic [7:0]             rx_byte,
  output logic                        cmd_ready,
  output logic                        rsp_valid,
  output logic [`TDC_DATA_W-1:0]      rsp_data,
  output logic                        start,
  output tdc_cmd_u                    tx_byte,
  output logic                        cs_end
);

  localparam logic [1:0] sq_idle  = 2'd0;
  localparam logic [1:0] sq_start = 2'd1; // start pulse to the shifter
  localparam logic [1:0] sq_wait  = 2'd2; // byte on the wire
  localparam logic [1:0] sq_resp  = 2'd3;

  logic [1:0]             state;
  logic                   wr_q;
  logic                   cmd_phase_q; // rx ignored while the command byte is out
  logic [1:0]             left_q;      // data bytes still to send
  logic [`TDC_DATA_W-1:0] tx_word;
  logic [`TDC_DATA_W-1:0] rsp_q;
  tdc_width_t             cmd_width;

  assign cmd_width = tdc_width_of(cmd_addr);
  assign cmd_ready = (state == sq_idle) && !rst;
  assign rsp_valid = (state == sq_resp);
  assign rsp_data  = rsp_q;
  assign start     = (state == sq_start);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= sq_idle;
      cs_end      <= 1'b0;
      cmd_phase_q <= 1'b0;
      left_q      <= '0;
    end else begin
      case (state)
        sq_idle: begin
          if (cmd_valid) begin
            cs_end      <= 1'b0;
            cmd_phase_q <= 1'b1;
            left_q      <= (cmd_width == tdc_wide) ? 2'd3 : 2'd1;
            state       <= sq_start;
          end
        end
        sq_start: state <= sq_wait;
        sq_wait: begin
          if (done) begin
            cmd_phase_q <= 1'b0;
            if (left_q == 2'd0) begin
              state <= sq_resp;
            end else begin
              left_q <= left_q - 1'b1;
              cs_end <= (left_q == 2'd1); // release cs after the last byte
              state  <= sq_start;
            end
          end
        end
        sq_resp: begin
          if (rsp_ready) begin
            state <= sq_idle;
          end
        end
        default: state <= sq_idle;
      endcase
    end
  end

  // latched command, outgoing bytes and read assembly
  always_ff @(posedge clk) begin
    if (state == sq_idle && cmd_valid) begin
      wr_q                    <= cmd_write;
      tx_byte.fields.auto_inc <= 1'b0; // burst access not used
      tx_byte.fields.rw       <= cmd_write;
      tx_byte.fields.addr     <= cmd_addr;
      rsp_q                   <= '0;
      if (cmd_width == tdc_wide) begin
        tx_word <= cmd_wdata;
      end else begin
        tx_word <= {cmd_wdata[7:0], {(`TDC_DATA_W - 8){1'b0}}}; // low byte only
      end
    end else if (state == sq_wait && done) begin
      if (!cmd_phase_q && !wr_q) begin
        rsp_q <= {rsp_q[`TDC_DATA_W-9:0], rx_byte}; // msb arrives first
      end
      if (left_q != 2'd0) begin
        tx_byte.raw <= tx_word[`TDC_DATA_W-1 -: 8];
        tx_word     <= tx_word << 8;
      end
    end
  end

  a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)));

  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    start |-> !busy);

endmodule

`default_nettype wire

/* verilog/tdc_spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tdc_params.svh"

// mode 0 byte shifter, sck low when idle, msb first
module tdc_spi_master import spi_pkg::*; #(
  parameter int SCK_HALF = `TDC_SCK_HALF
) (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       start,
  input  wire logic [7:0] tx_byte,
  input  wire logic       cs_end,
  input  wire logic       miso,
  output logic            busy,
  output logic            done,
  output logic [7:0]      rx_byte,
  output logic            sck,
  output logic            mosi,
  output logic            cs_n
);

  localparam int CNT_W = (SCK_HALF > 1) ? $clog2(2 * SCK_HALF) : 1;
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(SCK_HALF - 1);
  localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(2 * SCK_HALF - 1);

  spi_state_t       state;
  logic [CNT_W-1:0] cnt;      // position inside the current sck period
  logic [2:0]       bit_cnt;
  logic [7:0]       shreg;    // tx bits leave at the top, rx bits enter at the bottom
  logic [7:0]       rx_q;
  logic             sck_q;
  logic             mosi_q;
  logic             cs_q;
  logic             done_q;

  assign busy    = (state != spi_idle);
  assign done    = done_q;
  assign rx_byte = rx_q;
  assign sck     = sck_q;
  assign mosi    = mosi_q;
  assign cs_n    = cs_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= spi_idle;
      cnt     <= '0;
      bit_cnt <= '0;
      sck_q   <= 1'b0;
      mosi_q  <= 1'b0;
      cs_q    <= 1'b1;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        spi_idle: begin
          cnt     <= '0;
          bit_cnt <= '0;
          if (start) begin
            cs_q  <= 1'b0; // select first, data half a period later
            state <= spi_lead;
          end
        end
        spi_lead: begin
          if (cnt == HALF_LAST) begin
            cnt    <= '0;
            mosi_q <= tx_byte[7];
            state  <= spi_transfer;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        spi_transfer: begin
          if (cnt == FULL_LAST) begin
            // falling edge, next bit goes out while sck is low
            cnt     <= '0;
            sck_q   <= 1'b0;
            mosi_q  <= shreg[7];
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= spi_cs_decide;
            end
          end else begin
            cnt <= cnt + 1'b1;
            if (cnt == HALF_LAST) begin
              sck_q <= 1'b1; // rising edge, slave samples mosi
            end
          end
        end
        spi_cs_decide: begin
          if (cnt == HALF_LAST) begin
            cnt   <= '0;
            cs_q  <= cs_end; // keep selected unless this was the last byte
            state <= spi_cs_hold;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        spi_cs_hold: begin
          if (cnt == FULL_LAST) begin
            cnt    <= '0;
            done_q <= 1'b1;
            state  <= spi_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= spi_idle;
      endcase
    end
  end

  // shift register and received byte
  always_ff @(posedge clk) begin
    if (state == spi_lead && cnt == HALF_LAST) begin
      shreg <= tx_byte;
    end else if (state == spi_transfer && cnt == HALF_LAST) begin
      shreg <= {shreg[6:0], miso}; // miso taken on the rising edge
    end
    if (state == spi_transfer && cnt == FULL_LAST && bit_cnt == 3'd7) begin
      rx_q <= shreg;
    end
  end

  a_sck_idle_low: assert property (@(posedge clk) disable iff (rst)
    (state != spi_transfer) |-> !sck_q);

  // the sequencer must wait for the previous byte to finish
  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    start |-> !busy);

endmodule

`default_nettype wire

/* verilog/tdc_pkg.sv */
`default_nettype none

`include "tdc_params.svh"

package tdc_pkg;

  // command byte as the converter expects it, msb first on the wire
  typedef struct packed {
    logic                   auto_inc;
    logic                   rw;       // 1 = write
    logic [`TDC_ADDR_W-1:0] addr;
  } tdc_cmd_fields_t;

  // same byte seen raw by the shifter, by field by the sequencer
  typedef union packed {
    logic [7:0]      raw;
    tdc_cmd_fields_t fields;
  } tdc_cmd_u;

  typedef enum logic {
    tdc_narrow = 1'b0, // 8-bit config register
    tdc_wide   = 1'b1  // 24-bit measurement result
  } tdc_width_t;

  function automatic tdc_width_t tdc_width_of(input logic [`TDC_ADDR_W-1:0] addr);
    return (addr >= `TDC_WIDE_BASE) ? tdc_wide : tdc_narrow;
  endfunction

endpackage

`default_nettype wire

/* verilog/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // byte shifter phases, in the order a byte goes through them
  typedef enum logic [2:0] {
    spi_idle      = 3'd0,
    spi_lead      = 3'd1, // cs_n low, half period before first bit
    spi_transfer  = 3'd2,
    spi_cs_decide = 3'd3, // half period, then cs_n follows cs_end
    spi_cs_hold   = 3'd4  // one full period at the new cs_n level
  } spi_state_t;

endpackage

`default_nettype wire

/* verilog/tdc_params.svh */
`ifndef TDC_PARAMS_SVH
`define TDC_PARAMS_SVH

// system clocks per sck half period
`define TDC_SCK_HALF 2

// converter register map
`define TDC_ADDR_W 6
`define TDC_DATA_W 24

// addresses from here up are the 24-bit result registers
`define TDC_WIDE_BASE 16

`endif
